//--- files.f
rtl/sd_dat_pkg.sv
rtl/dat_serializer.sv
rtl/dat_deserializer.sv
rtl/dat_phys_controller.sv
rtl/sd_dat_regs.sv
rtl/sd_dat_top.sv
testbench/tb_clock.sv
testbench/sd_dat_tb.sv

//--- rtl/dat_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module dat_deserializer (
	input wire sd_clock,
	input wire reset,
	input wire listen,
	input wire token_mode,
	input wire dat_in,
	output logic rx_done,
	output logic [31:0] rx_word
);

	typedef enum logic [1:0] {
		HUNT,
		SHIFT,
		HOLD
	} phase_t;

	phase_t phase;
	logic [5:0] bit_cnt;
	logic [5:0] last_bit;

	assign last_bit = token_mode ? 6'd2 : 6'd31;

	always_ff @(posedge sd_clock)
	begin
		if (reset || !listen)
		begin
			phase <= HUNT;
			bit_cnt <= '0;
			rx_done <= 1'b0;
			rx_word <= '0;
		end
		else
		begin
			rx_done <= 1'b0;
			case (phase)
				HUNT:
				begin
					bit_cnt <= '0;
					if (!dat_in)
						phase <= SHIFT; // start bit
				end
				SHIFT:
				begin
					rx_word <= {rx_word[30:0], dat_in};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == last_bit)
					begin
						rx_done <= 1'b1;
						phase <= HOLD;
					end
				end
				// word stays put until listen drops
				default: phase <= HOLD;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/dat_phys_controller.sv
`timescale 1ns/1ps
`default_nettype none

module dat_phys_controller
	import sd_dat_pkg::*;
#(
	parameter int MAX_BLOCKS = 4,
	parameter int TIMEOUT_WIDTH = 16
)(
	input wire sd_clock,
	input wire reset,
	input wire strobe,
	input wire dat_cmd_t cmd,
	input wire ack,
	input wire [TIMEOUT_WIDTH-1:0] timeout_limit,
	output dat_status_t status,
	output logic [$clog2(MAX_BLOCKS)-1:0] block_index,
	output logic load,
	input wire tx_done,
	output logic listen,
	output logic token_mode,
	input wire rx_done,
	input wire [31:0] rx_word,
	output logic rx_store
);

	localparam int IDX_W = $clog2(MAX_BLOCKS);

	typedef enum logic [2:0] {
		IDLE,
		LOAD_WRITE,
		SEND,
		WAIT_RESPONSE,
		READ,
		STORE,
		DONE
	} state_t;

	state_t state;
	state_t next_state;
	logic [IDX_W-1:0] block_cnt;
	logic [TIMEOUT_WIDTH-1:0] timeout_cnt;
	logic timeout_q;
	logic token_err_q;
	logic waiting;
	logic last_block;
	logic expired;
	logic token_bad;

	assign waiting = (state == WAIT_RESPONSE) || (state == READ);
	assign last_block = !cmd.multiple || (block_cnt == IDX_W'(cmd.blocks_m1));
	assign expired = (timeout_cnt == timeout_limit);
	assign token_bad = (rx_word[2:0] != TOKEN_ACCEPTED);

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (strobe)
					next_state = cmd.write_read ? LOAD_WRITE : READ;
			LOAD_WRITE: next_state = SEND;
			SEND:
				if (tx_done)
					next_state = WAIT_RESPONSE;
			WAIT_RESPONSE:
			begin
				if (rx_done)
					next_state = (token_bad || last_block) ? DONE : LOAD_WRITE;
				else if (expired)
					next_state = DONE;
			end
			READ:
			begin
				if (rx_done)
					next_state = STORE;
				else if (expired)
					next_state = DONE;
			end
			STORE: next_state = last_block ? DONE : READ;
			DONE:
				if (ack)
					next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			state <= IDLE;
			block_cnt <= '0;
			timeout_cnt <= '0;
			timeout_q <= 1'b0;
			token_err_q <= 1'b0;
		end
		else
		begin
			state <= next_state;
			timeout_cnt <= waiting ? timeout_cnt + 1'b1 : '0; // only while listening
			if (state == IDLE)
				block_cnt <= '0;
			else if ((state == WAIT_RESPONSE && rx_done && next_state == LOAD_WRITE)
				|| (state == STORE && next_state == READ))
				block_cnt <= block_cnt + 1'b1;
			if (state == DONE && ack)
			begin
				timeout_q <= 1'b0;
				token_err_q <= 1'b0;
			end
			else
			begin
				if (waiting && !rx_done && expired)
					timeout_q <= 1'b1;
				if (state == WAIT_RESPONSE && rx_done && token_bad)
					token_err_q <= 1'b1;
			end
		end
	end

	assign load = (state == LOAD_WRITE);
	assign listen = waiting;
	assign token_mode = (state == WAIT_RESPONSE); // 3 bit status token
	assign rx_store = (state == STORE);
	assign block_index = block_cnt;

	always_comb
	begin
		status.busy = (state != IDLE);
		status.complete = (state == DONE);
		status.timeout = timeout_q;
		status.token_err = token_err_q;
	end

endmodule

`default_nettype wire

//--- rtl/dat_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module dat_serializer (
	input wire sd_clock,
	input wire reset,
	input wire load,
	input wire [31:0] tx_word,
	output logic dat_out,
	output logic dat_oe,
	output logic tx_done
);

	logic [33:0] shift;
	logic [5:0] bit_cnt;

	// line idles high when not driven
	assign dat_out = dat_oe ? shift[33] : 1'b1;

	always_ff @(posedge sd_clock)
	begin
		if (load)
			shift <= {1'b0, tx_word, 1'b1}; // start, data msb first, end
		else if (dat_oe)
			shift <= {shift[32:0], 1'b1};
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			dat_oe <= 1'b0;
			bit_cnt <= '0;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (load)
			begin
				dat_oe <= 1'b1;
				bit_cnt <= '0;
			end
			else if (dat_oe)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 6'd32)
					tx_done <= 1'b1; // lines up with the end bit
				if (bit_cnt == 6'd33)
					dat_oe <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/sd_dat_pkg.sv
`default_nettype none

package sd_dat_pkg;

	// command latched at start for the controller
	typedef struct packed {
		logic write_read;    // 1 = write
		logic multiple;
		logic [1:0] blocks_m1;
	} dat_cmd_t;

	typedef struct packed {
		logic busy;
		logic complete;
		logic timeout;
		logic token_err;
	} dat_status_t;

	typedef struct packed {
		logic [26:0] reserved;
		dat_cmd_t cmd;
		logic start;
	} ctrl_word_t;

	// one apb word seen as plain data or as the ctrl layout
	typedef union packed {
		logic [31:0] raw;
		ctrl_word_t ctrl_word;
	} apb_word_u;

	localparam logic [7:0] REG_CTRL    = 8'h00;
	localparam logic [7:0] REG_STATUS  = 8'h04;
	localparam logic [7:0] REG_TIMEOUT = 8'h08;
	localparam logic [7:0] REG_ACK     = 8'h0C;
	localparam logic [7:0] REG_TX_BASE = 8'h10;
	localparam logic [7:0] REG_RX_BASE = 8'h20;

	localparam logic [2:0] TOKEN_ACCEPTED = 3'b010;

endpackage

`default_nettype wire

//--- rtl/sd_dat_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sd_dat_regs
	import sd_dat_pkg::*;
#(
	parameter int MAX_BLOCKS = 4,
	parameter int TIMEOUT_WIDTH = 16
)(
	input wire sd_clock,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [7:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic strobe,
	output logic ack,
	output dat_cmd_t cmd,
	output logic [TIMEOUT_WIDTH-1:0] timeout_limit,
	input wire [$clog2(MAX_BLOCKS)-1:0] block_index,
	output logic [31:0] tx_word,
	input wire rx_store,
	input wire [31:0] rx_word,
	input wire dat_status_t status
);

	localparam int IDX_W = $clog2(MAX_BLOCKS);
	localparam logic [7:0] SPAN = 8'(4 * MAX_BLOCKS);

	logic [31:0] tx_buf [MAX_BLOCKS];
	logic [31:0] rx_buf [MAX_BLOCKS];
	logic [TIMEOUT_WIDTH-1:0] timeout_q;
	dat_cmd_t cmd_q;
	apb_word_u wr_word;
	apb_word_u rd_word;
	logic access;
	logic tx_hit;
	logic rx_hit;
	logic known;
	logic start_req;
	logic [IDX_W-1:0] word_idx;

	assign access = psel & penable;
	assign pready = 1'b1; // no wait states
	assign wr_word = pwdata;
	assign word_idx = paddr[IDX_W+1:2];

	assign tx_hit = (paddr[1:0] == 2'b00) && (paddr >= REG_TX_BASE) && (paddr < REG_TX_BASE + SPAN);
	assign rx_hit = (paddr[1:0] == 2'b00) && (paddr >= REG_RX_BASE) && (paddr < REG_RX_BASE + SPAN);
	assign known = tx_hit || rx_hit || paddr == REG_CTRL || paddr == REG_STATUS
		|| paddr == REG_TIMEOUT || paddr == REG_ACK;

	assign start_req = access && pwrite && paddr == REG_CTRL && wr_word.ctrl_word.start;
	assign strobe = start_req & ~status.busy;
	assign pslverr = access & (~known | (start_req & status.busy));
	assign ack = access && pwrite && paddr == REG_ACK;

	// new command is visible in the strobe cycle itself
	assign cmd = strobe ? wr_word.ctrl_word.cmd : cmd_q;
	assign timeout_limit = timeout_q;
	assign tx_word = tx_buf[block_index];

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			timeout_q <= '1; // longest wait until written
			cmd_q <= '0;
		end
		else
		begin
			if (strobe)
				cmd_q <= wr_word.ctrl_word.cmd;
			if (access && pwrite && paddr == REG_TIMEOUT)
				timeout_q <= wr_word.raw[TIMEOUT_WIDTH-1:0];
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (access && pwrite && tx_hit)
			tx_buf[word_idx] <= wr_word.raw;
		if (rx_store)
			rx_buf[block_index] <= rx_word;
	end

	always_comb
	begin
		rd_word = '0;
		if (access && !pwrite)
		begin
			case (paddr)
				REG_CTRL:
				begin
					rd_word.ctrl_word.cmd = cmd_q;
					rd_word.ctrl_word.start = status.busy;
				end
				REG_STATUS: rd_word.raw = 32'(status);
				REG_TIMEOUT: rd_word.raw = 32'(timeout_q);
				default:
				begin
					if (tx_hit)
						rd_word.raw = tx_buf[word_idx];
					else if (rx_hit)
						rd_word.raw = rx_buf[word_idx];
				end
			endcase
		end
		prdata = rd_word.raw;
	end

endmodule

`default_nettype wire

//--- rtl/sd_dat_top.sv
`timescale 1ns/1ps
`default_nettype none

module sd_dat_top
	import sd_dat_pkg::*;
#(
	parameter int MAX_BLOCKS = 4,
	parameter int TIMEOUT_WIDTH = 16
)(
	input wire sd_clock,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [7:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire dat_in,
	output logic dat_out,
	output logic dat_oe
);

	logic strobe;
	logic ack;
	dat_cmd_t cmd;
	dat_status_t status;
	logic [TIMEOUT_WIDTH-1:0] timeout_limit;
	logic [$clog2(MAX_BLOCKS)-1:0] block_index;
	logic [31:0] tx_word;
	logic [31:0] rx_word;
	logic rx_store;
	logic load;
	logic tx_done;
	logic listen;
	logic token_mode;
	logic rx_done;

	sd_dat_regs #(
		.MAX_BLOCKS(MAX_BLOCKS),
		.TIMEOUT_WIDTH(TIMEOUT_WIDTH)
	) i_regs (
		.sd_clock(sd_clock), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.strobe(strobe), .ack(ack), .cmd(cmd), .timeout_limit(timeout_limit),
		.block_index(block_index), .tx_word(tx_word),
		.rx_store(rx_store), .rx_word(rx_word), .status(status)
	);

	dat_phys_controller #(
		.MAX_BLOCKS(MAX_BLOCKS),
		.TIMEOUT_WIDTH(TIMEOUT_WIDTH)
	) i_ctrl (
		.sd_clock(sd_clock), .reset(reset),
		.strobe(strobe), .cmd(cmd), .ack(ack), .timeout_limit(timeout_limit),
		.status(status), .block_index(block_index),
		.load(load), .tx_done(tx_done),
		.listen(listen), .token_mode(token_mode),
		.rx_done(rx_done), .rx_word(rx_word), .rx_store(rx_store)
	);

	dat_serializer i_ser (
		.sd_clock(sd_clock), .reset(reset), .load(load), .tx_word(tx_word),
		.dat_out(dat_out), .dat_oe(dat_oe), .tx_done(tx_done)
	);

	dat_deserializer i_des (
		.sd_clock(sd_clock), .reset(reset), .listen(listen), .token_mode(token_mode),
		.dat_in(dat_in), .rx_done(rx_done), .rx_word(rx_word)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sd_dat_tb -f files.f -o sd_dat_sim
./obj_dir/sd_dat_sim > sim.log 2>&1
cat sim.log
if grep -qx "Test OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- testbench/sd_dat_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sd_dat_tb
	import sd_dat_pkg::*;
();

	localparam int MAX_BLOCKS = 4;
	localparam int TIMEOUT_WIDTH = 16;
	localparam logic [31:0] NORMAL_TIMEOUT = 32'd1000;
	localparam int POLL_LIMIT = 400;
	localparam int FRAME_WAIT = 100;

	logic sd_clock;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic dat_in;
	logic dat_out;
	logic dat_oe;

	integer seed;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int frame_count;
	logic oe_prev;
	logic [31:0] tx_model [MAX_BLOCKS];
	logic [31:0] rx_model [MAX_BLOCKS];

	tb_clock #(.PERIOD(8)) i_clk (.sd_clock(sd_clock));

	sd_dat_top #(
		.MAX_BLOCKS(MAX_BLOCKS),
		.TIMEOUT_WIDTH(TIMEOUT_WIDTH)
	) i_dut (
		.sd_clock(sd_clock), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.dat_in(dat_in), .dat_out(dat_out), .dat_oe(dat_oe)
	);

	// counts frames on the line by dat_oe rising
	always @(negedge sd_clock)
	begin
		if (reset)
			frame_count = 0;
		else if (dat_oe && !oe_prev)
			frame_count++;
		oe_prev = dat_oe;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic dat_cmd_t make_cmd(input logic wr, input logic mult, input int bm1);
		dat_cmd_t c;
		c.write_read = wr;
		c.multiple = mult;
		c.blocks_m1 = 2'(bm1);
		return c;
	endfunction

	function automatic int expected_blocks(input dat_cmd_t c);
		return c.multiple ? int'(c.blocks_m1) + 1 : 1;
	endfunction

	function automatic logic [31:0] status_word(input logic busy, input logic complete,
		input logic timeout, input logic token_err);
		dat_status_t s;
		s.busy = busy;
		s.complete = complete;
		s.timeout = timeout;
		s.token_err = token_err;
		return 32'(s);
	endfunction

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge sd_clock);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge sd_clock);
		#1;
		penable = 1'b1;
		@(negedge sd_clock); // outputs settled in the access phase
		rdata = prdata;
		err = pslverr;
		check_eq("pready", 32'h1, 32'(pready));
		@(posedge sd_clock);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_access(1'b1, addr, data, rd, err);
		check_eq("pslverr", 32'h0, 32'(err));
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
		logic err;
		apb_access(1'b0, addr, 32'h0, data, err);
		check_eq("pslverr", 32'h0, 32'(err));
	endtask

	task automatic start_transfer(input dat_cmd_t c);
		apb_word_u w;
		w.raw = '0;
		w.ctrl_word.start = 1'b1;
		w.ctrl_word.cmd = c;
		write_reg(REG_CTRL, w.raw);
	endtask

	task automatic poll_complete(output logic [31:0] st);
		int polls;
		dat_status_t cur;
		polls = 0;
		cur = '0;
		st = '0;
		while (!cur.complete && polls < POLL_LIMIT)
		begin
			read_reg(REG_STATUS, st);
			cur = dat_status_t'(st[3:0]);
			polls++;
		end
		check_true(cur.complete, "status poll timed out waiting for complete");
	endtask

	task automatic acknowledge();
		logic [31:0] st;
		write_reg(REG_ACK, 32'h0);
		read_reg(REG_STATUS, st);
		check_eq("status", status_word(1'b0, 1'b0, 1'b0, 1'b0), st);
	endtask

	// card drives a start bit and the value msb first and then idles high
	task automatic send_bits(input logic [31:0] value, input int nbits);
		int i;
		@(posedge sd_clock);
		#1;
		dat_in = 1'b0;
		for (i = nbits - 1; i >= 0; i--)
		begin
			@(posedge sd_clock);
			#1;
			dat_in = value[i];
		end
		@(posedge sd_clock);
		#1;
		dat_in = 1'b1;
	endtask

	task automatic capture_frame(output logic [33:0] bits, output logic seen);
		int waited;
		int i;
		waited = 0;
		seen = 1'b0;
		bits = '1;
		while (!seen && waited < FRAME_WAIT)
		begin
			@(negedge sd_clock);
			waited++;
			seen = dat_oe;
		end
		if (seen)
		begin
			bits[33] = dat_out; // start bit
			for (i = 32; i >= 0; i--)
			begin
				@(negedge sd_clock);
				bits[i] = dat_out;
			end
		end
	endtask

	task automatic run_write(input dat_cmd_t c, input int reject_at);
		int nblk;
		int n_frames;
		int frames_before;
		int b;
		logic [33:0] bits;
		logic seen;
		logic [31:0] st;
		logic [2:0] tok;
		nblk = expected_blocks(c);
		n_frames = (reject_at >= 0 && reject_at < nblk) ? reject_at + 1 : nblk;
		for (b = 0; b < MAX_BLOCKS; b++)
		begin
			tx_model[b] = $random(seed);
			write_reg(REG_TX_BASE + 8'(4 * b), tx_model[b]);
		end
		frames_before = frame_count;
		start_transfer(c);
		for (b = 0; b < n_frames; b++)
		begin
			capture_frame(bits, seen);
			check_true(seen, "no frame appeared on the DAT line");
			if (!seen)
				break;
			check_eq("start_bit", 32'h0, 32'(bits[33]));
			check_eq("end_bit", 32'h1, 32'(bits[0]));
			check_eq("dat_out", tx_model[b], bits[32:1]);
			tok = TOKEN_ACCEPTED;
			if (b == reject_at)
			begin
				tok = 3'(rand_range(0, 6));
				if (tok >= TOKEN_ACCEPTED)
					tok = tok + 3'd1; // anything but accepted
			end
			repeat (rand_range(2, 10)) @(posedge sd_clock);
			send_bits(32'(tok), 3);
		end
		poll_complete(st);
		check_eq("status", status_word(1'b1, 1'b1, 1'b0, reject_at >= 0), st);
		check_eq("frame_count", 32'(n_frames), 32'(frame_count - frames_before));
		acknowledge();
	endtask

	task automatic run_read(input dat_cmd_t c);
		int nblk;
		int b;
		logic [31:0] st;
		logic [31:0] rd;
		nblk = expected_blocks(c);
		start_transfer(c);
		for (b = 0; b < nblk; b++)
		begin
			rx_model[b] = $random(seed);
			repeat (rand_range(2, 10)) @(posedge sd_clock);
			send_bits(rx_model[b], 32);
		end
		poll_complete(st);
		check_eq("status", status_word(1'b1, 1'b1, 1'b0, 1'b0), st);
		for (b = 0; b < nblk; b++)
		begin
			read_reg(REG_RX_BASE + 8'(4 * b), rd);
			check_eq("rx_word", rx_model[b], rd);
		end
		acknowledge();
	endtask

	task automatic test_register_access();
		logic [31:0] rd;
		logic [31:0] t;
		logic err;
		int i;
		read_reg(REG_STATUS, rd);
		check_eq("status", 32'h0, rd);
		for (i = 0; i < MAX_BLOCKS; i++)
		begin
			tx_model[i] = $random(seed);
			write_reg(REG_TX_BASE + 8'(4 * i), tx_model[i]);
		end
		t = $random(seed);
		write_reg(REG_TIMEOUT, t);
		read_reg(REG_TIMEOUT, rd);
		check_eq("timeout_limit", 32'(t[TIMEOUT_WIDTH-1:0]), rd); // only the low bits are kept
		for (i = 0; i < MAX_BLOCKS; i++)
		begin
			read_reg(REG_TX_BASE + 8'(4 * i), rd);
			check_eq("tx_word", tx_model[i], rd);
		end
		apb_access(1'b0, 8'h3C, 32'h0, rd, err);
		check_eq("pslverr", 32'h1, 32'(err));
		write_reg(REG_TIMEOUT, NORMAL_TIMEOUT);
	endtask

	task automatic test_timeout();
		logic [31:0] st;
		logic [31:0] rd;
		logic err;
		apb_word_u w;
		write_reg(REG_TIMEOUT, 32'd20);
		start_transfer(make_cmd(1'b0, 1'b0, 0)); // card stays silent
		w.raw = '0;
		w.ctrl_word.start = 1'b1;
		w.ctrl_word.cmd = make_cmd(1'b1, 1'b1, 3);
		apb_access(1'b1, REG_CTRL, w.raw, rd, err);
		check_eq("pslverr", 32'h1, 32'(err));
		poll_complete(st);
		check_eq("status", status_word(1'b1, 1'b1, 1'b1, 1'b0), st);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	initial
	begin
		int mark;
		int i;
		seed = 32'h4dac778d;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		frame_count = 0;
		oe_prev = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		dat_in = 1'b1; // line idles high
		repeat (3) @(posedge sd_clock);
		#1;
		reset = 1'b0;

		mark = errors;
		test_register_access();
		finish_test("register access", mark);

		mark = errors;
		run_write(make_cmd(1'b1, 1'b0, rand_range(0, 3)), -1); // blocks_m1 ignored
		for (i = 0; i < 3; i++)
			run_write(make_cmd(1'b1, 1'b1, rand_range(0, 3)), -1);
		finish_test("single and multi-block write", mark);

		mark = errors;
		run_write(make_cmd(1'b1, 1'b1, 3), rand_range(0, 2));
		run_write(make_cmd(1'b1, 1'b0, 0), 0);
		finish_test("rejected token", mark);

		mark = errors;
		for (i = 0; i < 3; i++)
			run_read(make_cmd(1'b0, 1'b1, rand_range(0, 3)));
		finish_test("multi-block read", mark);

		mark = errors;
		test_timeout();
		finish_test("timeout", mark);

		mark = errors;
		acknowledge(); // clears the timeout left from before
		write_reg(REG_TIMEOUT, NORMAL_TIMEOUT);
		run_write(make_cmd(1'b1, 1'b1, rand_range(0, 3)), -1);
		finish_test("acknowledge", mark);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 8
)(
	output logic sd_clock
);

	initial
	begin
		sd_clock = 1'b0;
		forever
			#(PERIOD / 2) sd_clock = ~sd_clock;
	end

endmodule

`default_nettype wire
